// File: cache.f
hw/cache_pkg.sv
hw/cache_control.sv
hw/cache_datapath.sv
hw/cache_top.sv
bench/wb_memory.sv
bench/cache_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = cache_tb
FILELIST = cache.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/cache_tb.sv
`default_nettype none

module cache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int index_w = 3;
	localparam int line_adr_w = cache_pkg::addr_w - cache_pkg::offset_w;
	localparam int timeout_cycles = 40;

	logic                          clk;
	logic                          rst;
	logic                          cpu_cyc;
	logic                          cpu_stb;
	logic                          cpu_we;
	logic [cache_pkg::addr_w-1:0]  cpu_adr;
	logic [cache_pkg::data_w-1:0]  cpu_dat_w;
	logic [cache_pkg::data_w-1:0]  cpu_dat_r;
	logic                          cpu_ack;
	logic                          mem_cyc;
	logic                          mem_stb;
	logic                          mem_we;
	logic [line_adr_w-1:0]         mem_adr;
	logic [cache_pkg::line_w-1:0]  mem_dat_w;
	logic [cache_pkg::line_w-1:0]  mem_dat_r;
	logic                          mem_ack;
	logic [2:0]                    mem_latency;

	logic [31:0]                   lfsr;
	logic [31:0]                   shadow [int];
	int                            rd_count;
	int                            wr_count;
	int                            rd_mark;
	int                            wr_mark;
	logic [line_adr_w-1:0]         last_wr_adr;
	logic [cache_pkg::line_w-1:0]  last_wr_line;
	bit                            op_log [$]; // 1 for a write.

	cache_top #(
		.index_w (index_w)
	) dut_i (
		.clk       (clk),
		.rst       (rst),
		.cpu_cyc   (cpu_cyc),
		.cpu_stb   (cpu_stb),
		.cpu_we    (cpu_we),
		.cpu_adr   (cpu_adr),
		.cpu_dat_w (cpu_dat_w),
		.cpu_dat_r (cpu_dat_r),
		.cpu_ack   (cpu_ack),
		.mem_cyc   (mem_cyc),
		.mem_stb   (mem_stb),
		.mem_we    (mem_we),
		.mem_adr   (mem_adr),
		.mem_dat_w (mem_dat_w),
		.mem_dat_r (mem_dat_r),
		.mem_ack   (mem_ack)
	);

	wb_memory mem_i (
		.clk     (clk),
		.rst     (rst),
		.cyc     (mem_cyc),
		.stb     (mem_stb),
		.we      (mem_we),
		.adr     (mem_adr),
		.dat_w   (mem_dat_w),
		.dat_r   (mem_dat_r),
		.ack     (mem_ack),
		.latency (mem_latency)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// one count per acknowledged memory transfer.
	always @(negedge clk) begin : bus_monitor
		if (mem_cyc && mem_stb && mem_ack) begin
			op_log.push_back(mem_we);
			if (mem_we) begin
				wr_count++;
				last_wr_adr = mem_adr;
				last_wr_line = mem_dat_w;
			end else begin
				rd_count++;
			end
		end
	end

	// galois form, taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 32'h80200003;
		return out;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], lfsr_bit()};
		return r;
	endfunction

	function automatic logic [cache_pkg::addr_w-1:0] make_adr(input int tag, input int set,
			input int off);
		return cache_pkg::addr_w'((tag << (index_w + cache_pkg::offset_w)) |
			(set << cache_pkg::offset_w) | off);
	endfunction

	function automatic logic [31:0] init_word(input logic [cache_pkg::addr_w-1:0] a);
		return 32'(a) ^ 32'h5a5a0000;
	endfunction

	function automatic logic [31:0] expected_word(input logic [cache_pkg::addr_w-1:0] a);
		if (shadow.exists(int'(a)))
			return shadow[int'(a)];
		return init_word(a);
	endfunction

	function automatic logic [31:0] mem_word(input logic [cache_pkg::addr_w-1:0] a);
		logic [cache_pkg::line_w-1:0] line;
		line = mem_i.lines[a[cache_pkg::addr_w-1:cache_pkg::offset_w]];
		return line[a[cache_pkg::offset_w-1:0]*cache_pkg::data_w +: cache_pkg::data_w];
	endfunction

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR %0d ns: %s, got %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic mark_traffic();
		rd_mark = rd_count;
		wr_mark = wr_count;
		op_log.delete();
	endtask

	task automatic check_traffic(input string what, input int reads, input int writes);
		check_value({what, ": memory reads"}, 32'(rd_count - rd_mark), 32'(reads));
		check_value({what, ": memory writes"}, 32'(wr_count - wr_mark), 32'(writes));
	endtask

	// one wishbone request, held until ack.
	task automatic cpu_access(input logic we, input logic [cache_pkg::addr_w-1:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int cycles;
		@(posedge clk);
		#1;
		cpu_cyc = 1'b1;
		cpu_stb = 1'b1;
		cpu_we = we;
		cpu_adr = adr;
		cpu_dat_w = wdat;
		cycles = 0;
		@(negedge clk);
		while (cpu_ack !== 1'b1) begin
			cycles++;
			if (cycles > timeout_cycles) begin
				$display("no cpu ack within %0d cycles for address %h", timeout_cycles, adr);
				stop_run();
			end
			@(negedge clk);
		end
		rdat = cpu_dat_r;
		@(posedge clk);
		#1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
	endtask

	task automatic read_check(input logic [cache_pkg::addr_w-1:0] adr);
		logic [31:0] got;
		cpu_access(1'b0, adr, 32'h0, got);
		check_value($sformatf("read of %h", adr), got, expected_word(adr));
	endtask

	task automatic write_word(input logic [cache_pkg::addr_w-1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		cpu_access(1'b1, adr, dat, unused);
		shadow[int'(adr)] = dat;
	endtask

	task automatic first_read_after_reset();
		check_value("cpu_ack after reset", 32'(cpu_ack), 32'h0);
		check_value("mem_cyc after reset", 32'(mem_cyc), 32'h0);
		mark_traffic();
		read_check(make_adr(1, 2, 1));
		check_traffic("first read", 1, 0);
	endtask

	task automatic same_line_hits();
		mark_traffic();
		read_check(make_adr(1, 2, 0));
		read_check(make_adr(1, 2, 3));
		read_check(make_adr(1, 2, 2));
		check_traffic("same line reads", 0, 0);
	endtask

	task automatic write_hit_stays_in_cache();
		logic [cache_pkg::addr_w-1:0] a;
		a = make_adr(1, 2, 1);
		mark_traffic();
		write_word(a, 32'hdeadbeef);
		read_check(a);
		check_value("memory word after write hit", mem_word(a), init_word(a));
		check_traffic("write hit", 0, 0);
	endtask

	task automatic dirty_eviction();
		logic [cache_pkg::addr_w-1:0] a;
		a = make_adr(1, 2, 1);
		read_check(make_adr(2, 2, 0)); // fills the invalid way.
		mark_traffic();
		read_check(make_adr(3, 2, 0));
		check_traffic("dirty eviction", 1, 1);
		check_value("write-back before fill", 32'(op_log[0]), 32'h1);
		check_value("write-back line address", 32'(last_wr_adr), 32'(a >> cache_pkg::offset_w));
		check_value("written word in write-back line",
			last_wr_line[a[cache_pkg::offset_w-1:0]*cache_pkg::data_w +: cache_pkg::data_w],
			32'hdeadbeef);
		check_value("memory word after write-back", mem_word(a), 32'hdeadbeef);
	endtask

	task automatic lru_replacement();
		read_check(make_adr(4, 5, 0));
		read_check(make_adr(5, 5, 0));
		read_check(make_adr(4, 5, 0));
		mark_traffic();
		read_check(make_adr(6, 5, 0)); // replaces the second tag.
		check_traffic("lru replacement", 1, 0);
		mark_traffic();
		read_check(make_adr(4, 5, 0));
		check_traffic("recently used line kept", 0, 0);
		mark_traffic();
		read_check(make_adr(5, 5, 0));
		check_traffic("least recently used line evicted", 1, 0);
	endtask

	task automatic random_traffic();
		logic [cache_pkg::addr_w-1:0] a;
		logic                         we;
		int                           tag;
		int                           set;
		int                           off;
		for (int i = 0; i < 300; i++) begin
			mem_latency = 3'(random_bits(2) + 1);
			we = 1'(random_bits(1));
			tag = int'(random_bits(2)) + 8;
			set = int'(random_bits(2));
			off = int'(random_bits(2));
			a = make_adr(tag, set, off);
			if (we)
				write_word(a, random_bits(32));
			else
				read_check(a);
		end
		// two new tags per set push out both ways.
		for (int s = 0; s < (1 << index_w); s++) begin
			read_check(make_adr(100, s, 0));
			read_check(make_adr(101, s, 0));
		end
		foreach (shadow[k])
			check_value($sformatf("memory word %h after flush", k),
				mem_word(cache_pkg::addr_w'(k)), shadow[k]);
	endtask

	initial begin : main
		lfsr = 32'haa2e;
		rst = 1'b1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		cpu_adr = '0;
		cpu_dat_w = '0;
		mem_latency = 3'd2;
		rd_count = 0;
		wr_count = 0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		first_read_after_reset();
		same_line_hits();
		write_hit_stays_in_cache();
		dirty_eviction();
		lru_replacement();
		random_traffic();
		$display("PASS: all tests");
		$finish;
	end

endmodule : cache_tb

`default_nettype wire

// File: bench/wb_memory.sv
`default_nettype none

module wb_memory (
	input  wire                                              clk,
	input  wire                                              rst,
	input  logic                                             cyc,
	input  logic                                             stb,
	input  logic                                             we,
	input  logic [cache_pkg::addr_w-cache_pkg::offset_w-1:0] adr,
	input  logic [cache_pkg::line_w-1:0]                     dat_w,
	output logic [cache_pkg::line_w-1:0]                     dat_r,
	output logic                                             ack,
	input  logic [2:0]                                       latency
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int depth = 1 << (cache_pkg::addr_w - cache_pkg::offset_w);

	logic [cache_pkg::line_w-1:0] lines [depth];
	logic [2:0]                   wait_cnt;

	initial begin : fill
		logic [cache_pkg::addr_w-1:0] a;
		logic [cache_pkg::line_w-1:0] line;
		for (int l = 0; l < depth; l++) begin
			for (int w = 0; w < cache_pkg::words_per_line; w++) begin
				a = cache_pkg::addr_w'(l * cache_pkg::words_per_line + w);
				line[w*cache_pkg::data_w +: cache_pkg::data_w] = 32'(a) ^ 32'h5a5a0000;
			end
			lines[l] <= line;
		end
		dat_r <= '0;
		ack <= 1'b0;
		wait_cnt <= '0;
	end

	// ack comes latency cycles after stb, then drops for one cycle.
	always @(posedge clk) begin : respond
		if (rst) begin
			ack <= 1'b0;
			wait_cnt <= '0;
		end else if (cyc && stb && !ack) begin
			if (wait_cnt + 3'd1 >= latency) begin
				ack <= 1'b1;
				wait_cnt <= '0;
				if (we)
					lines[adr] <= dat_w;
				else
					dat_r <= lines[adr];
			end else begin
				wait_cnt <= wait_cnt + 3'd1;
			end
		end else begin
			ack <= 1'b0;
			wait_cnt <= '0;
		end
	end

endmodule : wb_memory

`default_nettype wire

// File: hw/cache_top.sv
`default_nettype none

module cache_top #(
	parameter int index_w = 3
) (
	input  wire                                             clk,
	input  wire                                             rst,
	input  logic                                            cpu_cyc,
	input  logic                                            cpu_stb,
	input  logic                                            cpu_we,
	input  logic [cache_pkg::addr_w-1:0]                    cpu_adr,
	input  logic [cache_pkg::data_w-1:0]                    cpu_dat_w,
	output logic [cache_pkg::data_w-1:0]                    cpu_dat_r,
	output logic                                            cpu_ack,
	output logic                                            mem_cyc,
	output logic                                            mem_stb,
	output logic                                            mem_we,
	output logic [cache_pkg::addr_w-cache_pkg::offset_w-1:0] mem_adr,
	output logic [cache_pkg::line_w-1:0]                    mem_dat_w,
	input  logic [cache_pkg::line_w-1:0]                    mem_dat_r,
	input  logic                                            mem_ack
);

	logic load_valid;
	logic load_dirty;
	logic clear_dirty;
	logic load_tag;
	logic load_data;
	logic load_lru;
	logic pmem_addr_sel;
	logic cache_in_sel;
	logic tag_hit;
	logic victim_valid;
	logic victim_dirty;

	cache_control control_i (
		.clk           (clk),
		.rst           (rst),
		.cpu_stb       (cpu_cyc && cpu_stb), // stb only counts inside a cycle.
		.cpu_we        (cpu_we),
		.tag_hit       (tag_hit),
		.victim_valid  (victim_valid),
		.victim_dirty  (victim_dirty),
		.mem_ack       (mem_ack),
		.cpu_ack       (cpu_ack),
		.load_valid    (load_valid),
		.load_dirty    (load_dirty),
		.clear_dirty   (clear_dirty),
		.load_tag      (load_tag),
		.load_data     (load_data),
		.load_lru      (load_lru),
		.pmem_addr_sel (pmem_addr_sel),
		.cache_in_sel  (cache_in_sel),
		.mem_cyc       (mem_cyc),
		.mem_stb       (mem_stb),
		.mem_we        (mem_we)
	);

	cache_datapath #(
		.index_w (index_w)
	) datapath_i (
		.clk           (clk),
		.rst           (rst),
		.cpu_adr       (cpu_adr),
		.cpu_dat_w     (cpu_dat_w),
		.cpu_dat_r     (cpu_dat_r),
		.load_valid    (load_valid),
		.load_dirty    (load_dirty),
		.clear_dirty   (clear_dirty),
		.load_tag      (load_tag),
		.load_data     (load_data),
		.load_lru      (load_lru),
		.pmem_addr_sel (pmem_addr_sel),
		.cache_in_sel  (cache_in_sel),
		.tag_hit       (tag_hit),
		.victim_valid  (victim_valid),
		.victim_dirty  (victim_dirty),
		.mem_adr       (mem_adr),
		.mem_dat_w     (mem_dat_w),
		.mem_dat_r     (mem_dat_r)
	);

endmodule : cache_top

`default_nettype wire

// File: hw/cache_datapath.sv
`default_nettype none

module cache_datapath #(
	parameter int index_w = 3
) (
	input  wire                                             clk,
	input  wire                                             rst,
	input  logic [cache_pkg::addr_w-1:0]                    cpu_adr,
	input  logic [cache_pkg::data_w-1:0]                    cpu_dat_w,
	output logic [cache_pkg::data_w-1:0]                    cpu_dat_r,
	input  logic                                            load_valid,
	input  logic                                            load_dirty,
	input  logic                                            clear_dirty,
	input  logic                                            load_tag,
	input  logic                                            load_data,
	input  logic                                            load_lru,
	input  logic                                            pmem_addr_sel,
	input  logic                                            cache_in_sel,
	output logic                                            tag_hit,
	output logic                                            victim_valid,
	output logic                                            victim_dirty,
	output logic [cache_pkg::addr_w-cache_pkg::offset_w-1:0] mem_adr,
	output logic [cache_pkg::line_w-1:0]                    mem_dat_w,
	input  logic [cache_pkg::line_w-1:0]                    mem_dat_r
);

	localparam int tag_w = cache_pkg::addr_w - index_w - cache_pkg::offset_w;
	localparam int sets = 1 << index_w;

	// two ways, one entry per set.
	logic [tag_w-1:0]              tag_arr [2][sets];
	logic [cache_pkg::line_w-1:0]  line_arr [2][sets];
	logic [sets-1:0]               valid_arr [2];
	logic [sets-1:0]               dirty_arr [2];
	logic [sets-1:0]               lru; // way to replace next.

	logic [tag_w-1:0]               req_tag;
	logic [index_w-1:0]             req_index;
	logic [cache_pkg::offset_w-1:0] req_offset;
	logic                           hit0;
	logic                           hit1;
	logic                           hit_way;
	logic                           victim_way;
	logic                           wr_way;
	logic [cache_pkg::line_w-1:0]   rd_line;
	logic [cache_pkg::line_w-1:0]   merged_line;
	logic [cache_pkg::line_w-1:0]   line_in;
	logic [tag_w-1:0]               victim_tag;

	assign req_tag = cpu_adr[cache_pkg::addr_w-1 -: tag_w];
	assign req_index = cpu_adr[cache_pkg::offset_w +: index_w];
	assign req_offset = cpu_adr[cache_pkg::offset_w-1:0];

	// hit detection over both ways.
	assign hit0 = valid_arr[0][req_index] && (tag_arr[0][req_index] == req_tag);
	assign hit1 = valid_arr[1][req_index] && (tag_arr[1][req_index] == req_tag);
	assign tag_hit = hit0 || hit1;
	assign hit_way = hit1;

	assign victim_way = lru[req_index];
	assign victim_valid = valid_arr[victim_way][req_index];
	assign victim_dirty = dirty_arr[victim_way][req_index];
	assign victim_tag = tag_arr[victim_way][req_index];

	// hit way on a write hit, victim way during a fill.
	assign wr_way = tag_hit ? hit_way : victim_way;

	assign rd_line = line_arr[hit_way][req_index];
	assign cpu_dat_r = rd_line[req_offset*cache_pkg::data_w +: cache_pkg::data_w];

	always_comb begin : word_merge
		for (int w = 0; w < cache_pkg::words_per_line; w++) begin
			if (cache_pkg::offset_w'(w) == req_offset)
				merged_line[w*cache_pkg::data_w +: cache_pkg::data_w] = cpu_dat_w;
			else
				merged_line[w*cache_pkg::data_w +: cache_pkg::data_w] =
					rd_line[w*cache_pkg::data_w +: cache_pkg::data_w];
		end
	end

	assign line_in = cache_in_sel ? merged_line : mem_dat_r;

	// write-back goes to the victim's own line address.
	assign mem_adr = pmem_addr_sel ? {victim_tag, req_index} : {req_tag, req_index};
	assign mem_dat_w = line_arr[victim_way][req_index];

	always_ff @(posedge clk) begin : status_bits
		if (rst) begin
			valid_arr[0] <= '0;
			valid_arr[1] <= '0;
			dirty_arr[0] <= '0;
			dirty_arr[1] <= '0;
			lru <= '0;
		end else begin
			if (load_valid)
				valid_arr[wr_way][req_index] <= 1'b1;
			if (load_dirty)
				dirty_arr[wr_way][req_index] <= 1'b1;
			else if (clear_dirty)
				dirty_arr[wr_way][req_index] <= 1'b0;
			if (load_lru)
				lru[req_index] <= ~hit_way; // point at the way not used.
		end
	end

	always_ff @(posedge clk) begin : storage
		if (load_tag)
			tag_arr[wr_way][req_index] <= req_tag;
		if (load_data)
			line_arr[wr_way][req_index] <= line_in;
	end

endmodule : cache_datapath

`default_nettype wire

// File: hw/cache_control.sv
`default_nettype none

module cache_control (
	input  wire  clk,
	input  wire  rst,
	input  logic cpu_stb,
	input  logic cpu_we,
	input  logic tag_hit,
	input  logic victim_valid,
	input  logic victim_dirty,
	input  logic mem_ack,
	output logic cpu_ack,
	output logic load_valid,
	output logic load_dirty,
	output logic clear_dirty,
	output logic load_tag,
	output logic load_data,
	output logic load_lru,
	output logic pmem_addr_sel,
	output logic cache_in_sel,
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we
);

	cache_pkg::ctrl_state_e state;
	cache_pkg::ctrl_state_e next_state;

	always_comb begin : state_actions
		cpu_ack = 1'b0;
		load_valid = 1'b0;
		load_dirty = 1'b0;
		clear_dirty = 1'b0;
		load_tag = 1'b0;
		load_data = 1'b0;
		load_lru = 1'b0;
		pmem_addr_sel = 1'b0;
		cache_in_sel = 1'b0;
		mem_cyc = 1'b0;
		mem_stb = 1'b0;
		mem_we = 1'b0;
		case (state)
			cache_pkg::cache_access: begin
				if (cpu_stb && tag_hit) begin
					cpu_ack = 1'b1; // same cycle as the request.
					load_lru = 1'b1;
					if (cpu_we) begin
						load_data = 1'b1;
						load_dirty = 1'b1;
						cache_in_sel = 1'b1; // merge the cpu word.
					end
				end
			end
			cache_pkg::physical_read: begin
				mem_cyc = 1'b1;
				mem_stb = 1'b1;
				if (mem_ack) begin
					// fill the victim way with the fetched line.
					load_data = 1'b1;
					load_tag = 1'b1;
					load_valid = 1'b1;
					clear_dirty = 1'b1;
				end
			end
			cache_pkg::physical_write: begin
				pmem_addr_sel = 1'b1; // victim tag and index.
				mem_cyc = 1'b1;
				mem_stb = 1'b1;
				mem_we = 1'b1;
			end
			default: begin
				cpu_ack = 1'b0;
			end
		endcase
	end

	always_comb begin : next_state_logic
		next_state = state;
		case (state)
			cache_pkg::cache_access: begin
				if (cpu_stb && !tag_hit) begin
					if (victim_valid && victim_dirty)
						next_state = cache_pkg::physical_write;
					else
						next_state = cache_pkg::physical_read;
				end
			end
			cache_pkg::physical_read: begin
				if (mem_ack)
					next_state = cache_pkg::cache_access; // line resident, hit next.
			end
			cache_pkg::physical_write: begin
				if (mem_ack)
					next_state = cache_pkg::physical_read;
			end
			default: begin
				next_state = cache_pkg::cache_access;
			end
		endcase
	end

	always_ff @(posedge clk) begin : state_reg
		if (rst)
			state <= cache_pkg::cache_access;
		else
			state <= next_state;
	end

endmodule : cache_control

`default_nettype wire

// File: hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// cpu side word geometry.
	localparam int addr_w = 16; // word address.
	localparam int data_w = 32;

	// line geometry.
	localparam int offset_w = 2;
	localparam int words_per_line = 1 << offset_w;
	localparam int line_w = data_w * words_per_line; // one line per memory beat.

	// miss handling states of the controller.
	typedef enum logic [1:0] {
		cache_access,
		physical_write,
		physical_read
	} ctrl_state_e;

endpackage : cache_pkg

`default_nettype wire
